/* Makefile */
VERILATOR  = verilator
TOP        = mprj_io_tb
RTL_TOP    = mprj_io_top
FILELIST   = vlog.f
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG) || (echo "Simulation ended without a result"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* common/mprj_pkg.sv */
package mprj_pkg;

    localparam int IO_CTRL_BITS = 13;

    // One pad's configuration word, sent MSB first down the chain
    typedef struct packed {
        logic [2:0] dm;            // Drive mode
        logic       trip_sel;
        logic       slow_slew;
        logic [2:0] analog;        // Enable, select and polarity
        logic       ib_sel;
        logic       inp_dis;       // Input disable, also the management output enable
        logic       hold_ovr;
        logic       oeb;           // Output enable, active low
        logic       mgmt_ena;
    } io_ctrl_t;

    // Reset values, the shadow defaults in the pad chain must agree
    localparam io_ctrl_t IOCTRL_BIDIR_DEF = 13'h1803;  // Pads 0 and 1
    localparam io_ctrl_t IOCTRL_INPUT_DEF = 13'h0403;  // Plain input pads

    // Byte offsets inside the register block
    localparam logic [7:0] XFER_OFS     = 8'h00;
    localparam logic [7:0] PWRDATA_OFS  = 8'h04;
    localparam logic [7:0] IODATA_OFS   = 8'h08;  // One word per 32 pads
    localparam logic [7:0] IOCONFIG_OFS = 8'h20;  // One word per pad

    // Wishbone request from the management CPU
    typedef struct packed {
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
        logic        we;
        logic        cyc;
        logic        stb;
    } wb_req_t;

    // Internal memory-style request seen by the register block
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [1:0]  wstrb;
    } iomem_req_t;

    // Daisy chain to the pad configuration blocks
    typedef struct packed {
        logic clock;
        logic resetn;
        logic data;
    } serial_bus_t;

endpackage

/* design/gpio_cfg_block.sv */
module gpio_cfg_block #(
    parameter mprj_pkg::io_ctrl_t DEFAULT_CFG = mprj_pkg::IOCTRL_INPUT_DEF
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  mprj_pkg::serial_bus_t serial_i,
    output logic                  serial_data_o,
    output mprj_pkg::io_ctrl_t    cfg_o
);
    import mprj_pkg::*;

    logic                    clk_q;     // Serial clock one cycle back
    logic                    shift_en;
    logic                    load_en;
    logic [IO_CTRL_BITS-1:0] shift_q;

    // Serial clock is a plain level in the clk domain
    assign shift_en = serial_i.clock && !clk_q;
    assign load_en  = serial_i.clock && !serial_i.resetn;

    assign serial_data_o = shift_q[IO_CTRL_BITS-1];  // Feeds the next pad

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            clk_q   <= 1'b0;
            shift_q <= '0;
        end else begin
            clk_q <= serial_i.clock;
            if (shift_en) begin
                shift_q <= {shift_q[IO_CTRL_BITS-2:0], serial_i.data};
            end
        end
    end

    // Shadow only changes on the load strobe
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            cfg_o <= DEFAULT_CFG;
        end else if (load_en) begin
            cfg_o <= shift_q;
        end
    end

endmodule

/* design/mprj_ctrl_wb.sv */
module mprj_ctrl_wb (
    input  logic                 clk,
    input  logic                 resetn,
    input  mprj_pkg::wb_req_t    wb_req_i,
    input  logic [31:0]          rdata_i,
    input  logic                 ready_i,
    output mprj_pkg::iomem_req_t iomem_o,
    output logic [31:0]          wb_dat_o,
    output logic                 wb_ack_o
);

    // Request side
    assign iomem_o.valid = wb_req_i.cyc && wb_req_i.stb;
    assign iomem_o.addr  = wb_req_i.adr;
    assign iomem_o.wdata = wb_req_i.dat;
    assign iomem_o.wstrb = wb_req_i.sel[1:0] & {2{wb_req_i.we}};  // Reads carry no strobes

    // Response side, ready is already a single-cycle pulse
    assign wb_dat_o = rdata_i;
    assign wb_ack_o = ready_i;

    // Register block must never stretch the acknowledge
    a_ack_single: assert property (
        @(posedge clk) disable iff (!resetn)
        wb_ack_o |=> !wb_ack_o
    );

    // An acknowledge outside a bus cycle means a dropped or stale request
    a_ack_in_cycle: assert property (
        @(posedge clk) disable iff (!resetn)
        wb_ack_o |-> wb_req_i.cyc
    );

endmodule

/* design/mprj_io_top.sv */
module mprj_io_top #(
    parameter logic [31:0] BASE_ADR = 32'h2300_0000,
    parameter int          NUM_PADS = 8,
    parameter int          NUM_PWR  = 4
) (
    input  logic                              clk,
    input  logic                              resetn,
    input  mprj_pkg::wb_req_t                 wb_req_i,
    input  logic [NUM_PADS-1:0]               mgmt_gpio_in_i,
    output logic [31:0]                       wb_dat_o,
    output logic                              wb_ack_o,
    output logic [NUM_PADS-1:0]               mgmt_gpio_out_o,
    output logic [NUM_PADS-1:0]               mgmt_gpio_en_o,
    output logic [NUM_PWR-1:0]                pwr_ctrl_o,
    output logic                              sdo_oenb_state_o,
    output logic                              jtag_oenb_state_o,
    output mprj_pkg::io_ctrl_t [NUM_PADS-1:0] pad_cfg_o
);
    import mprj_pkg::*;

    iomem_req_t              iomem;
    logic [31:0]             rdata;
    logic                    ready;
    logic                    xfer_start;
    logic                    busy;
    io_ctrl_t [NUM_PADS-1:0] io_ctrl;
    serial_bus_t             serial;
    logic [NUM_PADS:0]       chain_data;  // Bit i enters pad i

    assign chain_data[0] = serial.data;

    mprj_ctrl_wb mprj_ctrl_wb_i (
        .clk      (clk),
        .resetn   (resetn),
        .wb_req_i (wb_req_i),
        .rdata_i  (rdata),
        .ready_i  (ready),
        .iomem_o  (iomem),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o)
    );

    mprj_ctrl_regs #(
        .BASE_ADR (BASE_ADR),
        .NUM_PADS (NUM_PADS),
        .NUM_PWR  (NUM_PWR)
    ) mprj_ctrl_regs_i (
        .clk               (clk),
        .resetn            (resetn),
        .iomem_i           (iomem),
        .mgmt_gpio_in_i    (mgmt_gpio_in_i),
        .busy_i            (busy),
        .rdata_o           (rdata),
        .ready_o           (ready),
        .xfer_start_o      (xfer_start),
        .io_ctrl_o         (io_ctrl),
        .mgmt_gpio_out_o   (mgmt_gpio_out_o),
        .mgmt_gpio_en_o    (mgmt_gpio_en_o),
        .pwr_ctrl_o        (pwr_ctrl_o),
        .sdo_oenb_state_o  (sdo_oenb_state_o),
        .jtag_oenb_state_o (jtag_oenb_state_o)
    );

    mprj_serial_loader #(
        .NUM_PADS (NUM_PADS)
    ) mprj_serial_loader_i (
        .clk          (clk),
        .resetn       (resetn),
        .xfer_start_i (xfer_start),
        .io_ctrl_i    (io_ctrl),
        .busy_o       (busy),
        .serial_o     (serial)
    );

    // Pad chain, clock and strobe fan out while data ripples through
    for (genvar i = 0; i < NUM_PADS; i++) begin : g_pad
        serial_bus_t pad_serial;

        assign pad_serial = '{clock: serial.clock, resetn: serial.resetn, data: chain_data[i]};

        gpio_cfg_block #(
            .DEFAULT_CFG ((i < 2) ? IOCTRL_BIDIR_DEF : IOCTRL_INPUT_DEF)
        ) gpio_cfg_block_i (
            .clk           (clk),
            .resetn        (resetn),
            .serial_i      (pad_serial),
            .serial_data_o (chain_data[i+1]),
            .cfg_o         (pad_cfg_o[i])
        );
    end

endmodule

/* mprj_ctrl/mprj_ctrl_regs.sv */
module mprj_ctrl_regs #(
    parameter logic [31:0] BASE_ADR = 32'h2300_0000,
    parameter int          NUM_PADS = 8,
    parameter int          NUM_PWR  = 4
) (
    input  logic                              clk,
    input  logic                              resetn,
    input  mprj_pkg::iomem_req_t              iomem_i,
    input  logic [NUM_PADS-1:0]               mgmt_gpio_in_i,
    input  logic                              busy_i,
    output logic [31:0]                       rdata_o,
    output logic                              ready_o,
    output logic                              xfer_start_o,
    output mprj_pkg::io_ctrl_t [NUM_PADS-1:0] io_ctrl_o,
    output logic [NUM_PADS-1:0]               mgmt_gpio_out_o,
    output logic [NUM_PADS-1:0]               mgmt_gpio_en_o,
    output logic [NUM_PWR-1:0]                pwr_ctrl_o,
    output logic                              sdo_oenb_state_o,
    output logic                              jtag_oenb_state_o
);
    import mprj_pkg::*;

    localparam int IO_WORDS = (NUM_PADS + 31) / 32;

    logic [7:0]          offset;
    logic                hit;
    logic                wr_en;
    logic                xfer_sel;
    logic                pwr_sel;
    logic [IO_WORDS-1:0] io_data_sel;
    logic [NUM_PADS-1:0] io_ctrl_sel;
    logic [31:0]         io_word [IO_WORDS];  // GPIO inputs, zero-extended per word
    logic [31:0]         rdata_pre;

    // Accept once per request, ready low in between
    assign offset = iomem_i.addr[7:0];
    assign hit    = iomem_i.valid && !ready_o && (iomem_i.addr[31:8] == BASE_ADR[31:8]);
    assign wr_en  = hit && iomem_i.wstrb[0];  // Lane 0 only

    assign xfer_sel = (offset == XFER_OFS);
    assign pwr_sel  = (offset == PWRDATA_OFS);

    for (genvar w = 0; w < IO_WORDS; w++) begin : g_io_word
        localparam int LO    = w * 32;
        localparam int WIDTH = (NUM_PADS - LO < 32) ? NUM_PADS - LO : 32;

        assign io_data_sel[w] = (offset == 8'(IODATA_OFS + 4 * w));
        assign io_word[w]     = 32'(mgmt_gpio_in_i[LO +: WIDTH]);
    end

    for (genvar p = 0; p < NUM_PADS; p++) begin : g_pad
        assign io_ctrl_sel[p]    = (offset == 8'(IOCONFIG_OFS + 4 * p));
        assign mgmt_gpio_en_o[p] = io_ctrl_o[p].inp_dis;  // Drive only when input is off
    end

    // SDO and JTAG pads hand their OEB state back to the core
    assign sdo_oenb_state_o  = io_ctrl_o[1].oeb;
    assign jtag_oenb_state_o = io_ctrl_o[0].oeb;

    // Read mux, anything unmatched reads zero
    always_comb begin
        rdata_pre = '0;
        if (xfer_sel) begin
            rdata_pre = {31'b0, busy_i};
        end
        if (pwr_sel) begin
            rdata_pre = 32'(pwr_ctrl_o);
        end
        for (int w = 0; w < IO_WORDS; w++) begin
            if (io_data_sel[w]) begin
                rdata_pre = io_word[w];
            end
        end
        for (int p = 0; p < NUM_PADS; p++) begin
            if (io_ctrl_sel[p]) begin
                rdata_pre = {{(32 - IO_CTRL_BITS){1'b0}}, io_ctrl_o[p]};
            end
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            ready_o      <= 1'b0;
            xfer_start_o <= 1'b0;
        end else begin
            ready_o      <= hit;
            xfer_start_o <= wr_en && xfer_sel && iomem_i.wdata[0];
        end
    end

    always_ff @(posedge clk) begin
        if (hit) begin
            rdata_o <= rdata_pre;  // Valid with ready
        end
    end

    // Power bits and pad configuration words
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            pwr_ctrl_o <= '0;
            for (int p = 0; p < NUM_PADS; p++) begin
                io_ctrl_o[p] <= (p < 2) ? IOCTRL_BIDIR_DEF : IOCTRL_INPUT_DEF;
            end
        end else if (wr_en) begin
            if (pwr_sel) begin
                pwr_ctrl_o <= iomem_i.wdata[NUM_PWR-1:0];
            end
            for (int p = 0; p < NUM_PADS; p++) begin
                if (io_ctrl_sel[p]) begin
                    io_ctrl_o[p] <= iomem_i.wdata[IO_CTRL_BITS-1:0];
                end
            end
        end
    end

    // GPIO output data, 32 pads per word
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            mgmt_gpio_out_o <= '0;
        end else if (wr_en) begin
            for (int i = 0; i < NUM_PADS; i++) begin
                if (io_data_sel[i / 32]) begin
                    mgmt_gpio_out_o[i] <= iomem_i.wdata[i % 32];
                end
            end
        end
    end

    // Loader sees a single start per accepted write
    a_xfer_pulse: assert property (
        @(posedge clk) disable iff (!resetn)
        xfer_start_o |=> !xfer_start_o
    );

endmodule

/* mprj_ctrl/mprj_serial_loader.sv */
module mprj_serial_loader #(
    parameter int NUM_PADS = 8
) (
    input  logic                              clk,
    input  logic                              resetn,
    input  logic                              xfer_start_i,
    input  mprj_pkg::io_ctrl_t [NUM_PADS-1:0] io_ctrl_i,
    output logic                              busy_o,
    output mprj_pkg::serial_bus_t             serial_o
);
    import mprj_pkg::*;

    localparam int PAD_W = $clog2(NUM_PADS + 1);

    typedef enum logic [1:0] {
        IDLE,
        START,
        XBYTE,
        LOAD
    } state_t;

    state_t                  state;
    logic [3:0]              bit_cnt;  // Bit index in XBYTE, step in LOAD
    logic [PAD_W-1:0]        pad_cnt;  // Pads still to send
    logic [IO_CTRL_BITS-1:0] staging;
    logic                    ser_clk;
    logic                    ser_rstn;

    assign busy_o          = (state != IDLE);
    assign serial_o.clock  = ser_clk;
    assign serial_o.resetn = ser_rstn;
    assign serial_o.data   = staging[IO_CTRL_BITS-1];  // MSB first

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state    <= IDLE;
            bit_cnt  <= '0;
            pad_cnt  <= PAD_W'(NUM_PADS);
            staging  <= '0;
            ser_clk  <= 1'b0;
            ser_rstn <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    pad_cnt  <= PAD_W'(NUM_PADS);
                    ser_clk  <= 1'b0;
                    ser_rstn <= 1'b1;
                    if (xfer_start_i) begin
                        state <= START;
                    end
                end
                START: begin
                    // Highest pad goes first so it ends in the farthest block
                    pad_cnt <= pad_cnt - 1'b1;
                    staging <= io_ctrl_i[pad_cnt - 1'b1];
                    bit_cnt <= '0;
                    ser_clk <= 1'b0;
                    state   <= XBYTE;
                end
                XBYTE: begin
                    if (!ser_clk) begin
                        ser_clk <= 1'b1;  // Rising half, blocks sample here
                    end else if (bit_cnt == 4'(IO_CTRL_BITS - 1)) begin
                        // Clock stays high so the hand-over adds no edge
                        bit_cnt <= '0;
                        if (pad_cnt == '0) begin
                            state <= LOAD;
                        end else begin
                            state <= START;
                        end
                    end else begin
                        ser_clk <= 1'b0;
                        staging <= {staging[IO_CTRL_BITS-2:0], 1'b0};
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                LOAD: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    case (bit_cnt)
                        4'd0: ser_clk <= 1'b1;
                        4'd1: ser_rstn <= 1'b0;  // Latch strobe, clock still high
                        4'd2: ser_rstn <= 1'b1;
                        default: begin
                            ser_clk <= 1'b0;
                            state   <= IDLE;
                        end
                    endcase
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Latch strobe is a single LOAD cycle with the clock held high throughout
    a_load_strobe: assert property (
        @(posedge clk) disable iff (!resetn)
        $fell(ser_rstn) |-> (state == LOAD) && ser_clk ##1 ser_rstn && ser_clk
    );

endmodule

/* verif/mprj_io_tb.sv */
module mprj_io_tb;
    import mprj_pkg::*;

    localparam logic [31:0] BASE_ADR    = 32'h2300_0000;
    localparam int          NUM_PADS    = 8;
    localparam int          NUM_PWR     = 4;
    localparam int          RAND_ROUNDS = 3;

    // Write, read, drive GPIO inputs, start a transfer, wait for it to end
    typedef enum logic [2:0] {K_WR, K_RD, K_GPIN, K_START, K_WAIT} kind_t;

    typedef struct packed {
        kind_t       kind;
        logic [7:0]  ofs;
        logic [31:0] data;
        logic [31:0] exp;
    } entry_t;

    logic                    clk;
    logic                    resetn;
    wb_req_t                 wb_req;
    logic [NUM_PADS-1:0]     gpio_in;
    logic [31:0]             wb_dat;
    logic                    wb_ack;
    logic [NUM_PADS-1:0]     gpio_out;
    logic [NUM_PADS-1:0]     gpio_en;
    logic [NUM_PWR-1:0]      pwr_ctrl;
    logic                    sdo_oenb;
    logic                    jtag_oenb;
    io_ctrl_t [NUM_PADS-1:0] pad_cfg;

    entry_t              table_q[$];
    logic [31:0]         lfsr;
    io_ctrl_t            cfg_model [NUM_PADS];  // Register contents
    io_ctrl_t            pending [NUM_PADS];    // What the last transfer carried
    logic [NUM_PWR-1:0]  pwr_model;
    logic [NUM_PADS-1:0] gpio_model;
    int                  errors;
    int                  checks;
    int                  cycles;
    int                  cycle_limit;

    mprj_io_top #(
        .BASE_ADR (BASE_ADR),
        .NUM_PADS (NUM_PADS),
        .NUM_PWR  (NUM_PWR)
    ) mprj_io_top_i (
        .clk               (clk),
        .resetn            (resetn),
        .wb_req_i          (wb_req),
        .mgmt_gpio_in_i    (gpio_in),
        .wb_dat_o          (wb_dat),
        .wb_ack_o          (wb_ack),
        .mgmt_gpio_out_o   (gpio_out),
        .mgmt_gpio_en_o    (gpio_en),
        .pwr_ctrl_o        (pwr_ctrl),
        .sdo_oenb_state_o  (sdo_oenb),
        .jtag_oenb_state_o (jtag_oenb),
        .pad_cfg_o         (pad_cfg)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT stopped answering", cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [7:0] cfg_ofs(input int p);
        return 8'(IOCONFIG_OFS + 4 * p);
    endfunction

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic add_entry(input kind_t kind, input logic [7:0] ofs,
                             input logic [31:0] data, input logic [31:0] exp);
        table_q.push_back('{kind, ofs, data, exp});
    endtask

    task automatic build_table;
        logic [31:0] w;
        for (int p = 0; p < NUM_PADS; p++) begin
            add_entry(K_RD, cfg_ofs(p), '0, (p < 2) ? 32'h1803 : 32'h0403);
        end
        add_entry(K_RD, PWRDATA_OFS, '0, '0);
        add_entry(K_RD, IODATA_OFS, '0, '0);
        add_entry(K_RD, XFER_OFS, '0, '0);
        add_entry(K_WR, cfg_ofs(2), 32'hffff_e5a5, '0);
        add_entry(K_RD, cfg_ofs(2), '0, 32'h0000_05a5);  // 13 bits kept
        add_entry(K_WR, PWRDATA_OFS, 32'hffff_fff6, '0);
        add_entry(K_RD, PWRDATA_OFS, '0, 32'h6);
        add_entry(K_RD, 8'h0c, '0, '0);                  // Unmapped offsets
        add_entry(K_RD, cfg_ofs(NUM_PADS), '0, '0);
        add_entry(K_WR, IODATA_OFS, 32'h5a5a_5aa5, '0);
        for (int i = 0; i < 2; i++) begin
            rand_bits(NUM_PADS, w);
            add_entry(K_GPIN, IODATA_OFS, w, '0);
            add_entry(K_RD, IODATA_OFS, '0, w);
        end
        for (int p = 0; p < NUM_PADS; p++) begin
            rand_bits(16, w);
            add_entry(K_WR, cfg_ofs(p), w, '0);
            add_entry(K_RD, cfg_ofs(p), '0, {19'b0, w[12:0]});
        end
        add_entry(K_START, XFER_OFS, 32'h1, 32'h1);
        add_entry(K_WAIT, XFER_OFS, '0, '0);
        add_entry(K_RD, XFER_OFS, '0, '0);
        // Last pad is rewritten while busy and only shows up one round later
        for (int r = 0; r < RAND_ROUNDS; r++) begin
            for (int p = 0; p < NUM_PADS - 1; p++) begin
                rand_bits(16, w);
                add_entry(K_WR, cfg_ofs(p), w, '0);
            end
            add_entry(K_START, XFER_OFS, 32'h1, 32'h1);
            rand_bits(16, w);
            add_entry(K_WR, cfg_ofs(NUM_PADS - 1), w, '0);
            add_entry(K_RD, cfg_ofs(NUM_PADS - 1), '0, {19'b0, w[12:0]});
            add_entry(K_WAIT, XFER_OFS, '0, '0);
        end
        add_entry(K_START, XFER_OFS, 32'h1, 32'h1);
        add_entry(K_WAIT, XFER_OFS, '0, '0);
    endtask

    // One Wishbone access, cyc and stb held through the acknowledge edge
    task automatic bus_xfer(input logic we, input logic [7:0] ofs, input logic [31:0] wdata,
                            output logic [31:0] rdata);
        @(negedge clk);
        wb_req.adr = {BASE_ADR[31:8], ofs};
        wb_req.dat = wdata;
        wb_req.sel = 4'hf;
        wb_req.we  = we;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        do begin
            @(negedge clk);
        end while (!wb_ack);
        rdata = wb_dat;
        @(negedge clk);
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
    endtask

    task automatic check_pins;
        logic [NUM_PADS-1:0] en_exp;
        for (int p = 0; p < NUM_PADS; p++) begin
            en_exp[p] = cfg_model[p].inp_dis;
        end
        check("pwr_ctrl_o", 32'(pwr_ctrl), 32'(pwr_model));
        check("mgmt_gpio_out_o", 32'(gpio_out), 32'(gpio_model));
        check("mgmt_gpio_en_o", 32'(gpio_en), 32'(en_exp));
        check("sdo_oenb_state_o", 32'(sdo_oenb), 32'(cfg_model[1].oeb));
        check("jtag_oenb_state_o", 32'(jtag_oenb), 32'(cfg_model[0].oeb));
    endtask

    task automatic check_shadow;
        for (int p = 0; p < NUM_PADS; p++) begin
            check($sformatf("pad_cfg_o[%0d]", p), {19'b0, pad_cfg[p]}, {19'b0, pending[p]});
        end
    endtask

    task automatic apply_entry(input entry_t e);
        logic [31:0] rd;
        case (e.kind)
            K_WR: begin
                bus_xfer(1'b1, e.ofs, e.data, rd);
                if (e.ofs == PWRDATA_OFS) begin
                    pwr_model = e.data[NUM_PWR-1:0];
                end
                if (e.ofs == IODATA_OFS) begin
                    gpio_model = e.data[NUM_PADS-1:0];
                end
                if (e.ofs >= IOCONFIG_OFS && e.ofs < cfg_ofs(NUM_PADS)) begin
                    cfg_model[(e.ofs - IOCONFIG_OFS) / 4] = e.data[IO_CTRL_BITS-1:0];
                end
            end
            K_RD: begin
                bus_xfer(1'b0, e.ofs, '0, rd);
                check($sformatf("wb_dat_o at offset %02h", e.ofs), rd, e.exp);
            end
            K_GPIN: begin
                @(negedge clk);
                gpio_in = e.data[NUM_PADS-1:0];
            end
            K_START: begin
                bus_xfer(1'b1, e.ofs, e.data, rd);
                pending = cfg_model;  // Snapshot at the start
                bus_xfer(1'b0, e.ofs, '0, rd);
                check("busy", {31'b0, rd[0]}, e.exp);
            end
            K_WAIT: begin
                rd = 32'h1;
                while (rd[0]) begin
                    bus_xfer(1'b0, e.ofs, '0, rd);  // Poll busy
                end
                check_shadow;
            end
            default: begin
            end
        endcase
        check_pins;
    endtask

    initial begin
        resetn      = 1'b0;
        wb_req      = '0;
        gpio_in     = '0;
        errors      = 0;
        checks      = 0;
        cycles      = 0;
        lfsr        = 32'hdd7a_6931;
        pwr_model   = '0;
        gpio_model  = '0;
        for (int p = 0; p < NUM_PADS; p++) begin
            cfg_model[p] = (p < 2) ? 13'h1803 : 13'h0403;
            pending[p]   = cfg_model[p];
        end
        build_table;
        cycle_limit = table_q.size() * (NUM_PADS * 27 + 20) + 200;
        repeat (4) @(negedge clk);
        resetn = 1'b1;
        check_pins;
        check_shadow;
        foreach (table_q[i]) begin
            apply_entry(table_q[i]);
        end
        @(negedge clk);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
common/mprj_pkg.sv
design/mprj_ctrl_wb.sv
mprj_ctrl/mprj_ctrl_regs.sv
mprj_ctrl/mprj_serial_loader.sv
design/gpio_cfg_block.sv
design/mprj_io_top.sv
verif/mprj_io_tb.sv
